//--- common/msk_tx_pkg.sv
`default_nettype none

package msk_tx_pkg;

   ////////////////////////////////
   // widths and levels

   parameter int word_w  = 32;    // ping-pong buffer word
   parameter int addr_w  = 14;    // buffer address, covers both banks
   parameter int iq_w    = 9;     // one DAC channel, signed
   parameter int msk_amp = 200;   // |level| for a 1 or a 0 bit

   ////////////////////////////////
   // types

   typedef logic [word_w-1:0] tx_word_t;

   // burst controller states
   typedef enum logic [1:0] {
      st_idle = 2'd0,   // waiting for a qualified slot
      st_load = 2'd1,   // bank picked, first word addressed
      st_send = 2'd2,   // words streaming out
      st_tail = 2'd3    // last bit gone, enable still held
   } tx_state_e;

   // one serialized bit, serializer -> mapper
   typedef struct packed {
      logic value;      // bit level, MSB first
      logic valid;      // first clock of the bit only
      logic first;      // bit 0 of a burst
   } bit_strobe_t;

   // offset I/Q pair, also the 18 bit DAC word
   typedef struct packed {
      logic signed [iq_w-1:0] i;
      logic signed [iq_w-1:0] q;
   } iq_sample_t;

endpackage

`default_nettype wire

//--- hw/tx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tx_ctrl import msk_tx_pkg::*; #(
   parameter int unsigned burst_words = 40,
   parameter int unsigned pong_base   = 6000,
   parameter int unsigned tail_cycles = 200000
) (
   input  wire        clk_50m,
   input  wire        cfg_rst,

   input  wire        slot_interrupt_i,   // single clock pulse
   input  wire        dsp_start_send_i,   // qualifies the slot
   input  wire        word_done_i,        // last clock of a word's bit 31

   output logic [addr_w-1:0] read_addr_o,
   output logic       word_load_o,        // one clock, address already valid
   output logic       burst_active_o      // first bit .. end of tail
);

   localparam int cnt_w  = $clog2(burst_words + 1);
   localparam int tail_w = $clog2(tail_cycles + 1);

   tx_state_e         state_q;
   logic              bank_q;        // 0: next burst reads bank 0
   logic [cnt_w-1:0]  word_cnt_q;    // words handed to the serializer
   logic [tail_w-1:0] tail_cnt_q;

   logic slot_ok;
   logic all_loaded;
   logic last_load;

   ////////////////////////////////
   // slot qualify, word bookkeeping

   assign slot_ok    = slot_interrupt_i & dsp_start_send_i;
   assign all_loaded = (word_cnt_q == cnt_w'(burst_words));       // no more reloads
   assign last_load  = (word_cnt_q == cnt_w'(burst_words - 1));   // load in flight is the last

   ////////////////////////////////
   // burst FSM

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         state_q        <= st_idle;
         bank_q         <= 1'b0;
         read_addr_o    <= '0;
         word_cnt_q     <= '0;
         tail_cnt_q     <= '0;
         word_load_o    <= 1'b0;
         burst_active_o <= 1'b0;
      end
      else begin
         word_load_o <= 1'b0;   // pulse by default

         case (state_q)
            st_idle: begin
               // slot pulses outside idle are dropped, bank untouched
               if (slot_ok) begin
                  state_q     <= st_load;
                  read_addr_o <= bank_q ? addr_w'(pong_base) : '0;   // ping or pong
                  bank_q      <= ~bank_q;                            // other half next time
                  word_cnt_q  <= '0;
               end
            end

            st_load: begin
               word_load_o <= 1'b1;   // first word, 2 clocks after the slot
               state_q     <= st_send;
            end

            st_send: begin
               if (word_load_o) begin
                  word_cnt_q     <= word_cnt_q + 1'b1;
                  burst_active_o <= 1'b1;   // lines up with the first strobe
                  if (!last_load) begin
                     read_addr_o <= read_addr_o + 1'b1;   // stays on last word at the end
                  end
               end

               if (word_done_i) begin
                  if (all_loaded) begin
                     state_q    <= st_tail;
                     tail_cnt_q <= '0;
                  end
                  else begin
                     word_load_o <= 1'b1;   // next word, no gap between bits
                  end
               end
            end

            st_tail: begin
               // enable window after the final bit
               if (tail_cnt_q == tail_w'(tail_cycles)) begin
                  state_q        <= st_idle;
                  burst_active_o <= 1'b0;
               end
               else begin
                  tail_cnt_q <= tail_cnt_q + 1'b1;
               end
            end

            default: state_q <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- msk/word_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module word_serializer import msk_tx_pkg::*; #(
   parameter int unsigned bit_cycles = 2344
) (
   input  wire         clk_50m,
   input  wire         cfg_rst,

   input  wire         word_load_i,   // capture send_data_i now
   input  tx_word_t    send_data_i,

   output bit_strobe_t bit_o,         // registered, 1 clock after load
   output logic        word_done_o    // last clock of bit 31
);

   localparam int tmr_w = $clog2(bit_cycles + 1);

   logic [tmr_w-1:0] tmr_q;     // clock within the current bit
   logic [4:0]       idx_q;     // bit index, 0 = MSB
   logic             active_q;  // a word is being shifted
   tx_word_t         sr_q;      // bits still to go, next at MSB

   logic             bit_end;
   logic             bit_start;
   logic [tmr_w-1:0] tmr_nxt;

   assign bit_end     = (tmr_q == tmr_w'(bit_cycles - 1));
   assign bit_start   = (tmr_q == '0);
   assign tmr_nxt     = bit_end ? '0 : tmr_q + 1'b1;   // wrap at bit_cycles
   assign word_done_o = active_q & bit_end & (idx_q == 5'd31);

   ////////////////////////////////
   // bit timer and strobe

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         tmr_q    <= '0;
         idx_q    <= '0;
         active_q <= 1'b0;
         bit_o    <= '0;
      end
      else begin
         bit_o.valid <= 1'b0;
         bit_o.first <= 1'b0;
         if (word_load_i) begin
            active_q    <= 1'b1;
            idx_q       <= '0;
            tmr_q       <= tmr_nxt;                   // tmr_q is 0 here
            bit_o.value <= send_data_i[word_w-1];   // MSB first
            bit_o.valid <= 1'b1;
            bit_o.first <= ~active_q;                 // load out of idle starts a burst
         end
         else if (active_q) begin
            if (bit_start && idx_q == 5'd31) begin
               active_q <= 1'b0;   // no reload came, burst over
               tmr_q    <= '0;
            end
            else begin
               tmr_q <= tmr_nxt;
               if (bit_start) begin
                  idx_q       <= idx_q + 1'b1;
                  bit_o.value <= sr_q[word_w-1];
                  bit_o.valid <= 1'b1;
               end
            end
         end
      end
   end

   // shift register, payload only
   always_ff @(posedge clk_50m) begin
      if (word_load_i) begin
         sr_q <= {send_data_i[word_w-2:0], 1'b0};   // MSB already out
      end
      else if (active_q && bit_start) begin
         sr_q <= {sr_q[word_w-2:0], 1'b0};
      end
   end

endmodule

`default_nettype wire

//--- msk/msk_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module msk_mapper import msk_tx_pkg::*; (
   input  wire         clk_50m,
   input  wire         cfg_rst,

   input  bit_strobe_t bit_i,            // from the serializer
   input  wire         burst_active_i,   // DAC window from the controller

   output iq_sample_t  dac_out_o,        // {i, q}, 18 bits
   output logic        tx_en_o
);

   localparam logic signed [iq_w-1:0] amp_pos = iq_w'(msk_amp);
   localparam logic signed [iq_w-1:0] amp_neg = -amp_pos;

   iq_sample_t             iq_q;      // held channel levels
   logic                   q_sel_q;   // 0: next bit goes to I
   logic signed [iq_w-1:0] lvl;

   assign lvl = bit_i.value ? amp_pos : amp_neg;   // 1 -> +amp, 0 -> -amp

   ////////////////////////////////
   // offset I/Q, even bits on I, odd bits on Q

   always_ff @(posedge clk_50m or posedge cfg_rst) begin
      if (cfg_rst) begin
         iq_q    <= '0;
         q_sel_q <= 1'b0;
         tx_en_o <= 1'b0;
      end
      else begin
         tx_en_o <= burst_active_i;
         if (!burst_active_i) begin
            iq_q    <= '0;     // DAC idles at zero outside the window
            q_sel_q <= 1'b0;
         end
         else if (bit_i.valid) begin
            // other channel keeps its level
            if (bit_i.first || !q_sel_q) begin
               iq_q.i  <= lvl;    // bit 0 of a burst always on I
               q_sel_q <= 1'b1;
            end
            else begin
               iq_q.q  <= lvl;
               q_sel_q <= 1'b0;
            end
         end
      end
   end

   assign dac_out_o = iq_q;

endmodule

`default_nettype wire

//--- hw/msk_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module msk_tx_top import msk_tx_pkg::*; #(
   parameter int unsigned bit_cycles  = 2344,     // 50 MHz clocks per bit
   parameter int unsigned burst_words = 40,       // words read per slot
   parameter int unsigned pong_base   = 6000,     // second bank start
   parameter int unsigned tail_cycles = 200000    // enable hold after last bit, 4 ms
) (
   input  wire        clk_50m,
   input  wire        cfg_rst,

   input  wire        slot_interrupt_i,   // one clock pulse per slot
   input  wire        dsp_start_send_i,   // level, DSP has filled the buffer
   input  tx_word_t   send_data_i,        // word at read_addr_o, no latency

   output logic [addr_w-1:0] read_addr_o,
   output iq_sample_t dac_out_o,          // {i, q}
   output logic       tx_en_o
);

   ////////////////////////////////
   // internal nets

   logic        word_load;      // ctrl -> serializer
   logic        word_done;      // serializer -> ctrl
   logic        burst_active;   // first bit through end of tail
   bit_strobe_t bit_strb;

   ////////////////////////////////
   // burst control, ping-pong addressing

   tx_ctrl #(
      .burst_words (burst_words),
      .pong_base   (pong_base),
      .tail_cycles (tail_cycles)
   ) u_tx_ctrl (
      .clk_50m          (clk_50m),
      .cfg_rst          (cfg_rst),
      .slot_interrupt_i (slot_interrupt_i),
      .dsp_start_send_i (dsp_start_send_i),
      .word_done_i      (word_done),
      .read_addr_o      (read_addr_o),
      .word_load_o      (word_load),
      .burst_active_o   (burst_active)
   );

   ////////////////////////////////
   // word -> bits, MSB first

   word_serializer #(
      .bit_cycles (bit_cycles)
   ) u_word_serializer (
      .clk_50m     (clk_50m),
      .cfg_rst     (cfg_rst),
      .word_load_i (word_load),
      .send_data_i (send_data_i),
      .bit_o       (bit_strb),
      .word_done_o (word_done)
   );

   // bits -> offset I/Q levels on the DAC
   msk_mapper u_msk_mapper (
      .clk_50m        (clk_50m),
      .cfg_rst        (cfg_rst),
      .bit_i          (bit_strb),
      .burst_active_i (burst_active),
      .dac_out_o      (dac_out_o),
      .tx_en_o        (tx_en_o)
   );

endmodule

`default_nettype wire

//--- verification/msk_tx_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module msk_tx_assertions import msk_tx_pkg::*; #(
   parameter int unsigned burst_words = 40,
   parameter int unsigned pong_base   = 6000
) (
   input wire               clk_50m,
   input wire               cfg_rst,
   input wire               slot_interrupt_i,
   input wire  [addr_w-1:0] read_addr_i,
   input iq_sample_t        dac_out_i,
   input wire               tx_en_i
);

   int assert_fails = 0;   // failed properties so far

   //////////////////////////////
   // DAC idles at zero outside the enable window
   a_dac_zero_off: assert property (@(posedge clk_50m) disable iff (cfg_rst)
      !tx_en_i |-> (dac_out_i == '0))
      else begin
         $error("dac_out_o not zero while tx_en_o is low");
         assert_fails++;
      end

   // slot sampled 4 clocks before the enable comes up
   a_en_after_slot: assert property (@(posedge clk_50m) disable iff (cfg_rst)
      $rose(tx_en_i) |-> $past(slot_interrupt_i, 4))
      else begin
         $error("tx_en_o rose without a slot pulse 4 cycles earlier");
         assert_fails++;
      end

   // ping or pong, never between
   a_addr_in_bank: assert property (@(posedge clk_50m) disable iff (cfg_rst)
      (read_addr_i < burst_words) ||
      (read_addr_i >= pong_base && read_addr_i < pong_base + burst_words))
      else begin
         $error("read_addr_o outside both banks");
         assert_fails++;
      end

endmodule

bind msk_tx_top msk_tx_assertions #(
   .burst_words (burst_words),
   .pong_base   (pong_base)
) u_msk_tx_assertions (
   .clk_50m          (clk_50m),
   .cfg_rst          (cfg_rst),
   .slot_interrupt_i (slot_interrupt_i),
   .read_addr_i      (read_addr_o),
   .dac_out_i        (dac_out_o),
   .tx_en_i          (tx_en_o)
);

`default_nettype wire

//--- verification/tb_msk_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msk_tx import msk_tx_pkg::*; ();

   localparam int bit_cycles  = 4;
   localparam int burst_words = 3;
   localparam int pong_base   = 6000;
   localparam int tail_cycles = 10;
   localparam int ev_base     = 7;   // first event word in the stim file

   logic              clk_50m;
   logic              cfg_rst;
   logic              slot_interrupt;
   logic              dsp_start_send;
   tx_word_t          send_data;
   logic [addr_w-1:0] read_addr;
   iq_sample_t        dac_out;
   logic              tx_en;

   tx_word_t    buf_mem [0:(1<<addr_w)-1];   // ping-pong buffer model
   logic [31:0] stim_mem [0:63];
   int          checks_running;   // bursts still being followed

   assign send_data = buf_mem[read_addr];   // zero latency read

   msk_tx_top #(
      .bit_cycles  (bit_cycles),
      .burst_words (burst_words),
      .pong_base   (pong_base),
      .tail_cycles (tail_cycles)
   ) dut0 (
      .clk_50m          (clk_50m),
      .cfg_rst          (cfg_rst),
      .slot_interrupt_i (slot_interrupt),
      .dsp_start_send_i (dsp_start_send),
      .send_data_i      (send_data),
      .read_addr_o      (read_addr),
      .dac_out_o        (dac_out),
      .tx_en_o          (tx_en)
   );

   initial begin
      clk_50m = 1'b0;
      forever #10 clk_50m = ~clk_50m;   // 50 MHz
   end

   task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
         $display("Regression failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // bound property failures stop the run too
   always @(negedge clk_50m) begin
      if (dut0.u_msk_tx_assertions.assert_fails != 0) begin
         $display("a concurrent assertion on the DUT ports failed, see the error above");
         $display("Regression failed");
         $fatal(1, "assertion failure");
      end
   end

   //////////////////////////////
   // follows one accepted burst from its slot edge
   task automatic follow_burst(input int bank);
      int                     base;
      int                     n_bits;
      int                     c;
      int                     k;
      tx_word_t               word;
      logic                   b;
      logic signed [iq_w-1:0] exp_i;
      logic signed [iq_w-1:0] exp_q;
      base   = bank ? pong_base : 0;
      n_bits = burst_words * word_w;
      exp_i  = '0;
      exp_q  = '0;
      @(posedge clk_50m);   // slot sampled, cycle 0
      @(posedge clk_50m);
      @(negedge clk_50m);
      check_val("read_addr at burst start", read_addr, base);
      @(posedge clk_50m);
      @(negedge clk_50m);
      check_val("tx_en before first bit", tx_en, 0);
      @(posedge clk_50m);   // first bit on the DAC from here
      for (c = 0; c < n_bits * bit_cycles + tail_cycles; c++) begin
         @(negedge clk_50m);
         k = c / bit_cycles;
         if (k < n_bits && c % bit_cycles == 0) begin
            word = buf_mem[base + k / word_w];
            b    = word[word_w - 1 - k % word_w];   // MSB first
            if (k % 2 == 0)
               exp_i = b ? iq_w'(msk_amp) : iq_w'(-msk_amp);   // even bits on I
            else
               exp_q = b ? iq_w'(msk_amp) : iq_w'(-msk_amp);
         end
         check_val("tx_en inside window", tx_en, 1);
         if (k >= n_bits || c % bit_cycles == bit_cycles / 2)
            check_val("dac level", dac_out, {exp_i, exp_q});   // mid-bit, then tail hold
         if (k < n_bits && c % (word_w * bit_cycles) == (word_w / 2) * bit_cycles &&
             k / word_w < burst_words - 1)
            check_val("read_addr mid word", read_addr, base + k / word_w + 1);
         @(posedge clk_50m);
      end
      @(negedge clk_50m);
      check_val("tx_en after tail", tx_en, 0);
      check_val("dac after tail", dac_out, 0);
      checks_running--;
   endtask

   //////////////////////////////
   // stimulus
   initial begin
      int unsigned rnd;
      int          a;
      int          e;
      int          n_ev;
      int          ev_delay;
      int          ev_dsp;
      int          ev_bank;
      int          next_bank;
      int          limit;
      cfg_rst        = 1'b1;
      slot_interrupt = 1'b0;
      dsp_start_send = 1'b0;
      checks_running = 0;
      next_bank      = 0;
      rnd            = $urandom(32'hd838);
      for (a = 0; a < (1 << addr_w); a++)
         buf_mem[a] = (32'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;   // whole address in the fill
      $readmemh("verification/msk_tx_stim.txt", stim_mem);
      for (a = 0; a < 3; a++) begin
         buf_mem[a]             = stim_mem[a];
         buf_mem[pong_base + a] = stim_mem[3 + a];
      end
      n_ev  = stim_mem[6];
      limit = 0;
      for (e = 0; e < n_ev; e++)
         limit += stim_mem[ev_base + 3 * e] + 60 +
                  burst_words * word_w * bit_cycles + tail_cycles + 16;
      limit = 2 * limit;
      fork
         begin
            repeat (limit) @(posedge clk_50m);
            $display("watchdog: run did not finish within %0d cycles", limit);
            $display("Regression failed");
            $fatal(1, "timeout");
         end
      join_none
      repeat (3) @(posedge clk_50m);
      #1 cfg_rst = 1'b0;
      @(negedge clk_50m);
      check_val("tx_en after reset", tx_en, 0);
      check_val("dac after reset", dac_out, 0);
      check_val("read_addr after reset", read_addr, 0);
      for (e = 0; e < n_ev; e++) begin
         ev_delay = stim_mem[ev_base + 3 * e];
         ev_dsp   = stim_mem[ev_base + 3 * e + 1];
         ev_bank  = stim_mem[ev_base + 3 * e + 2];
         if (ev_bank != 2)
            wait (checks_running == 0);   // controller back in idle first
         repeat (ev_delay + 20 + $urandom % 41) @(posedge clk_50m);   // idle gap
         #1;
         dsp_start_send = ev_dsp[0];
         slot_interrupt = 1'b1;
         if (ev_bank != 2) begin
            check_val("bank order in stim", ev_bank, next_bank);   // banks alternate
            next_bank ^= 1;
            checks_running++;
            fork
               follow_burst(ev_bank);
            join_none
         end
         @(posedge clk_50m);
         #1 slot_interrupt = 1'b0;
         if (ev_bank == 2 && checks_running == 0) begin
            repeat (8) @(posedge clk_50m);
            @(negedge clk_50m);
            check_val("tx_en after ignored slot", tx_en, 0);
         end
      end
      wait (checks_running == 0);
      repeat (5) @(posedge clk_50m);
      if (dut0.u_msk_tx_assertions.assert_fails == 0) begin
         $display("Regression passed");
         $finish;
      end
      else begin
         $display("a concurrent assertion on the DUT ports failed, see the error above");
         $display("Regression failed");
         $fatal(1, "assertion failure");
      end
   end

endmodule

`default_nettype wire

//--- msk_tx_top.f
common/msk_tx_pkg.sv
hw/tx_ctrl.sv
msk/word_serializer.sv
msk/msk_mapper.sv
hw/msk_tx_top.sv
verification/msk_tx_assertions.sv
verification/tb_msk_tx.sv

//--- Bender.yml
package:
  name: msk_tx

sources:
  - common/msk_tx_pkg.sv
  - hw/tx_ctrl.sv
  - msk/word_serializer.sv
  - msk/msk_mapper.sv
  - hw/msk_tx_top.sv
  - target: simulation
    files:
      - verification/msk_tx_assertions.sv
      - verification/tb_msk_tx.sv

//--- verification/msk_tx_stim.txt
// words 0..2 go to addr 0..2, words 3..5 to pong_base..pong_base+2, then the event count
// each event, all hex: idle_delay_cycles  dsp_start_send  expected_bank (2 = no burst)
A5C30F96
3C9E71B4
FF00AA55
0123BEEF
96E4D21C
7B1F08C3
0000000A
// first burst out of reset
00000000 00000001 00000000
// slot during the burst, dropped
00000064 00000001 00000002
00000000 00000001 00000001
// dsp not ready, dropped
00000190 00000000 00000002
00000000 00000001 00000000
00000190 00000000 00000002
00000000 00000000 00000002
00000000 00000001 00000001
// second in-burst slot
000000C8 00000001 00000002
0000012C 00000001 00000000
